// ==== src/rvPkg.sv ====
`default_nettype none

package rvPkg;

	// data path and address width
	parameter int xlen = 32;

	// register index width
	parameter int regAddrW = 5;

	// major opcodes handled by the core
	typedef enum logic [6:0] {
		// all-zero word left behind by a flushed register
		opNop    = 7'b0000000,
		opLoad   = 7'b0000011,
		opStore  = 7'b0100011,
		opRtype  = 7'b0110011,
		opItype  = 7'b0010011,
		opBranch = 7'b1100011,
		opJal    = 7'b1101111
	} opcodeT;

	// ALU operations, branches use aluSub
	typedef enum logic [3:0] {
		aluAdd  = 4'd0,
		aluSub  = 4'd1,
		aluAnd  = 4'd2,
		aluOr   = 4'd3,
		aluXor  = 4'd4,
		aluSll  = 4'd5,
		aluSrl  = 4'd6,
		aluSra  = 4'd7,
		aluSlt  = 4'd8,
		aluSltu = 4'd9
	} aluOpT;

	// immediate formats
	typedef enum logic [2:0] {
		immI      = 3'd0,
		immIShift = 3'd1,
		immS      = 3'd2,
		immB      = 3'd3,
		immJ      = 3'd4
	} immSrcT;

	// writeback source
	typedef enum logic [1:0] {
		resAlu     = 2'd0,
		resMem     = 2'd1,
		resPcPlus4 = 2'd2
	} resultSrcT;

	// operand forward select for execute
	typedef enum logic [1:0] {
		fwdNone = 2'd0,
		fwdWb   = 2'd1,
		fwdMem  = 2'd2
	} fwdSelT;

endpackage

`default_nettype wire

// ==== src/fetchStage.sv ====
`default_nettype none

module fetchStage #(
	parameter logic [rvPkg::xlen-1:0] resetPc = '0
) (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   stall,
	input  logic                   pcSrc,
	input  logic [rvPkg::xlen-1:0] pcTarget,
	output logic [rvPkg::xlen-1:0] pc,
	output logic [rvPkg::xlen-1:0] pcPlus4
);

	import rvPkg::*;

	logic [xlen-1:0] pcNext;

	assign pcPlus4 = pc + xlen'(4);

	// redirect from execute wins over sequential fetch
	assign pcNext = pcSrc ? pcTarget : pcPlus4;

	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= resetPc;
		end else if (!stall) begin
			pc <= pcNext;
		end
	end

endmodule

`default_nettype wire

// ==== src/decodeUnit.sv ====
`default_nettype none

module decodeUnit (
	input  logic [rvPkg::xlen-1:0] instr,
	output logic                   regWrite,
	output logic                   memWrite,
	output logic                   branch,
	output logic                   jump,
	output logic                   aluBSrc,
	output logic                   branchOnNe,
	output rvPkg::resultSrcT       resultSrc,
	output rvPkg::aluOpT           aluOp,
	output logic [rvPkg::xlen-1:0] immExt
);

	import rvPkg::*;

	localparam logic [2:0] f3AddSub = 3'b000;
	localparam logic [2:0] f3Sll    = 3'b001;
	localparam logic [2:0] f3Slt    = 3'b010;
	localparam logic [2:0] f3Sltu   = 3'b011;
	localparam logic [2:0] f3Xor    = 3'b100;
	localparam logic [2:0] f3Srl    = 3'b101;
	localparam logic [2:0] f3Or     = 3'b110;
	localparam logic [2:0] f3And    = 3'b111;
	localparam logic [2:0] f3Word   = 3'b010;
	localparam logic [2:0] f3Beq    = 3'b000;
	localparam logic [2:0] f3Bne    = 3'b001;

	opcodeT     opcode;
	logic [2:0] funct3;
	logic       funct7b5;
	immSrcT     immSrc;
	aluOpT      aluRi;

	assign opcode   = opcodeT'(instr[6:0]);
	assign funct3   = instr[14:12];
	assign funct7b5 = instr[30];

	// ALU operation shared by R-type and I-type
	always_comb begin
		case (funct3)
			// only R-type has sub, addi keeps bit 30 as immediate
			f3AddSub: aluRi = (opcode == opRtype && funct7b5) ? aluSub : aluAdd;
			f3Sll:    aluRi = aluSll;
			f3Slt:    aluRi = aluSlt;
			f3Sltu:   aluRi = aluSltu;
			f3Xor:    aluRi = aluXor;
			f3Srl:    aluRi = funct7b5 ? aluSra : aluSrl;
			f3Or:     aluRi = aluOr;
			f3And:    aluRi = aluAnd;
			default:  aluRi = aluAdd;
		endcase
	end

	// main decoder, anything unrecognised stays a bubble
	always_comb begin
		regWrite   = 1'b0;
		memWrite   = 1'b0;
		branch     = 1'b0;
		jump       = 1'b0;
		aluBSrc    = 1'b0;
		branchOnNe = 1'b0;
		resultSrc  = resAlu;
		aluOp      = aluAdd;
		immSrc     = immI;
		case (opcode)
			opLoad: begin
				if (funct3 == f3Word) begin
					regWrite  = 1'b1;
					aluBSrc   = 1'b1;
					resultSrc = resMem;
				end
			end
			opStore: begin
				if (funct3 == f3Word) begin
					memWrite = 1'b1;
					aluBSrc  = 1'b1;
					immSrc   = immS;
				end
			end
			opRtype: begin
				regWrite = 1'b1;
				aluOp    = aluRi;
			end
			opItype: begin
				regWrite = 1'b1;
				aluBSrc  = 1'b1;
				aluOp    = aluRi;
				if (funct3 == f3Sll || funct3 == f3Srl) begin
					immSrc = immIShift;
				end
			end
			opBranch: begin
				if (funct3 == f3Beq || funct3 == f3Bne) begin
					branch     = 1'b1;
					branchOnNe = (funct3 == f3Bne);
					aluOp      = aluSub;
					immSrc     = immB;
				end
			end
			opJal: begin
				regWrite  = 1'b1;
				jump      = 1'b1;
				resultSrc = resPcPlus4;
				immSrc    = immJ;
			end
			// flushed slot keeps the defaults
			opNop: ;
			default: ;
		endcase
	end

	// immediate extender
	always_comb begin
		case (immSrc)
			immIShift: immExt = {{(xlen-5){1'b0}}, instr[24:20]};
			immS:      immExt = {{20{instr[31]}}, instr[31:25], instr[11:7]};
			immB:      immExt = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
			immJ:      immExt = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
			default:   immExt = {{20{instr[31]}}, instr[31:20]};
		endcase
	end

endmodule

`default_nettype wire

// ==== src/regFile.sv ====
`default_nettype none

module regFile (
	input  logic                       clk,
	input  logic                       rst,
	input  logic [rvPkg::regAddrW-1:0] readAddr1,
	input  logic [rvPkg::regAddrW-1:0] readAddr2,
	output logic [rvPkg::xlen-1:0]     readData1,
	output logic [rvPkg::xlen-1:0]     readData2,
	input  logic                       writeEn,
	input  logic [rvPkg::regAddrW-1:0] writeAddr,
	input  logic [rvPkg::xlen-1:0]     writeData
);

	import rvPkg::*;

	logic [xlen-1:0] regs [2**regAddrW];

	// falling-edge write so decode sees it in the same cycle
	always_ff @(negedge clk) begin
		if (rst) begin
			for (int i = 0; i < 2**regAddrW; i++) begin
				regs[i] <= '0;
			end
		end else if (writeEn && writeAddr != '0) begin
			regs[writeAddr] <= writeData;
		end
	end

	// x0 is hardwired to zero
	assign readData1 = (readAddr1 == '0) ? '0 : regs[readAddr1];
	assign readData2 = (readAddr2 == '0) ? '0 : regs[readAddr2];

endmodule

`default_nettype wire

// ==== src/executeStage.sv ====
`default_nettype none

module executeStage (
	input  logic [rvPkg::xlen-1:0] rd1,
	input  logic [rvPkg::xlen-1:0] rd2,
	input  logic [rvPkg::xlen-1:0] pcE,
	input  logic [rvPkg::xlen-1:0] immExt,
	input  logic [rvPkg::xlen-1:0] aluResultM,
	input  logic [rvPkg::xlen-1:0] resultW,
	input  rvPkg::fwdSelT          fwdA,
	input  rvPkg::fwdSelT          fwdB,
	input  logic                   aluBSrc,
	input  logic                   branch,
	input  logic                   jump,
	input  logic                   branchOnNe,
	input  rvPkg::aluOpT           aluOp,
	output logic [rvPkg::xlen-1:0] aluResult,
	output logic [rvPkg::xlen-1:0] storeData,
	output logic [rvPkg::xlen-1:0] pcTarget,
	output logic                   pcSrc
);

	import rvPkg::*;

	localparam int shW = $clog2(xlen);

	logic [xlen-1:0] srcA;
	logic [xlen-1:0] srcB;
	logic [shW-1:0]  shamt;
	logic            zero;

	// forwarding muxes, memory stage is the newer value
	always_comb begin
		case (fwdA)
			fwdMem:  srcA = aluResultM;
			fwdWb:   srcA = resultW;
			default: srcA = rd1;
		endcase
		case (fwdB)
			fwdMem:  storeData = aluResultM;
			fwdWb:   storeData = resultW;
			default: storeData = rd2;
		endcase
	end

	assign srcB  = aluBSrc ? immExt : storeData;
	assign shamt = srcB[shW-1:0];

	always_comb begin
		case (aluOp)
			aluSub:  aluResult = srcA - srcB;
			aluAnd:  aluResult = srcA & srcB;
			aluOr:   aluResult = srcA | srcB;
			aluXor:  aluResult = srcA ^ srcB;
			aluSll:  aluResult = srcA << shamt;
			aluSrl:  aluResult = srcA >> shamt;
			aluSra:  aluResult = $signed(srcA) >>> shamt;
			aluSlt:  aluResult = xlen'($signed(srcA) < $signed(srcB));
			aluSltu: aluResult = xlen'(srcA < srcB);
			default: aluResult = srcA + srcB;
		endcase
	end

	assign zero = (aluResult == '0);

	// BEQ takes on zero, BNE on non-zero
	assign pcSrc    = jump | (branch & (zero ^ branchOnNe));
	assign pcTarget = pcE + immExt;

endmodule

`default_nettype wire

// ==== src/hazardUnit.sv ====
`default_nettype none

module hazardUnit (
	input  logic [rvPkg::regAddrW-1:0] rs1D,
	input  logic [rvPkg::regAddrW-1:0] rs2D,
	input  logic [rvPkg::regAddrW-1:0] rs1E,
	input  logic [rvPkg::regAddrW-1:0] rs2E,
	input  logic [rvPkg::regAddrW-1:0] rdE,
	input  logic [rvPkg::regAddrW-1:0] rdM,
	input  logic [rvPkg::regAddrW-1:0] rdW,
	input  logic                       loadE,
	input  logic                       regWriteM,
	input  logic                       regWriteW,
	input  logic                       pcSrc,
	output rvPkg::fwdSelT              fwdA,
	output rvPkg::fwdSelT              fwdB,
	output logic                       stallF,
	output logic                       stallD,
	output logic                       flushD,
	output logic                       flushE
);

	import rvPkg::*;

	logic loadStall;

	// memory stage first, x0 never forwards
	function automatic fwdSelT pickFwd(input logic [regAddrW-1:0] rs);
		if (rs != '0 && regWriteM && rs == rdM) begin
			return fwdMem;
		end else if (rs != '0 && regWriteW && rs == rdW) begin
			return fwdWb;
		end
		return fwdNone;
	endfunction

	always_comb begin
		fwdA = pickFwd(rs1E);
		fwdB = pickFwd(rs2E);
	end

	// load result not ready for the instruction behind it
	assign loadStall = loadE && rdE != '0 && (rdE == rs1D || rdE == rs2D);

	assign stallF = loadStall;
	assign stallD = loadStall;
	assign flushD = pcSrc;
	assign flushE = loadStall | pcSrc;

endmodule

`default_nettype wire

// ==== src/rvPipeTop.sv ====
`default_nettype none

module rvPipeTop #(
	parameter logic [rvPkg::xlen-1:0] resetPc = '0
) (
	input  logic                   clk,
	input  logic                   rst,
	output logic [rvPkg::xlen-1:0] pc,
	input  logic [rvPkg::xlen-1:0] instr,
	output logic [rvPkg::xlen-1:0] dataAddr,
	output logic [rvPkg::xlen-1:0] writeData,
	output logic                   memWrite,
	input  logic [rvPkg::xlen-1:0] readData
);

	import rvPkg::*;

	// hazard and redirect
	logic   stallF, stallD, flushD, flushE;
	fwdSelT fwdA, fwdB;
	logic   pcSrc;
	logic [xlen-1:0] pcTarget, pcPlus4F;

	// decode
	logic [xlen-1:0] instrD, pcD, pcPlus4D, rd1D, rd2D, immExtD;
	logic regWriteD, memWriteD, branchD, jumpD, aluBSrcD, branchOnNeD;
	resultSrcT resultSrcD;
	aluOpT     aluOpD;

	// execute
	logic [xlen-1:0] rd1E, rd2E, pcE, immExtE, pcPlus4E, aluResultE, storeDataE;
	logic [regAddrW-1:0] rs1E, rs2E, rdE;
	logic regWriteE, memWriteE, branchE, jumpE, aluBSrcE, branchOnNeE;
	resultSrcT resultSrcE;
	aluOpT     aluOpE;

	// memory and writeback
	logic [xlen-1:0] aluResultM, writeDataM, pcPlus4M;
	logic [xlen-1:0] aluResultW, readDataW, pcPlus4W, resultW;
	logic [regAddrW-1:0] rdM, rdW;
	logic regWriteM, memWriteM, regWriteW;
	resultSrcT resultSrcM, resultSrcW;

	fetchStage #(.resetPc(resetPc)) fetch (
		.clk(clk), .rst(rst), .stall(stallF), .pcSrc(pcSrc),
		.pcTarget(pcTarget), .pc(pc), .pcPlus4(pcPlus4F)
	);

	// IF/ID, a flushed word decodes as opNop
	always_ff @(posedge clk) begin
		if (rst || flushD) begin
			instrD <= '0;
		end else if (!stallD) begin
			instrD <= instr;
		end
	end

	always_ff @(posedge clk) begin
		if (!stallD) begin
			pcD      <= pc;
			pcPlus4D <= pcPlus4F;
		end
	end

	decodeUnit decode (
		.instr(instrD), .regWrite(regWriteD), .memWrite(memWriteD), .branch(branchD),
		.jump(jumpD), .aluBSrc(aluBSrcD), .branchOnNe(branchOnNeD),
		.resultSrc(resultSrcD), .aluOp(aluOpD), .immExt(immExtD)
	);

	regFile regs (
		.clk(clk), .rst(rst), .readAddr1(instrD[19:15]), .readAddr2(instrD[24:20]),
		.readData1(rd1D), .readData2(rd2D), .writeEn(regWriteW),
		.writeAddr(rdW), .writeData(resultW)
	);

	// ID/EX control and register indices
	always_ff @(posedge clk) begin
		if (rst || flushE) begin
			{regWriteE, memWriteE, branchE, jumpE, aluBSrcE, branchOnNeE} <= '0;
			resultSrcE <= resAlu;
			aluOpE     <= aluAdd;
			{rs1E, rs2E, rdE} <= '0;
		end else begin
			{regWriteE, memWriteE, branchE, jumpE} <= {regWriteD, memWriteD, branchD, jumpD};
			{aluBSrcE, branchOnNeE} <= {aluBSrcD, branchOnNeD};
			resultSrcE <= resultSrcD;
			aluOpE     <= aluOpD;
			{rs1E, rs2E, rdE} <= {instrD[19:15], instrD[24:20], instrD[11:7]};
		end
	end

	always_ff @(posedge clk) begin
		{rd1E, rd2E, immExtE} <= {rd1D, rd2D, immExtD};
		{pcE, pcPlus4E}       <= {pcD, pcPlus4D};
	end

	executeStage execute (
		.rd1(rd1E), .rd2(rd2E), .pcE(pcE), .immExt(immExtE),
		.aluResultM(aluResultM), .resultW(resultW), .fwdA(fwdA), .fwdB(fwdB),
		.aluBSrc(aluBSrcE), .branch(branchE), .jump(jumpE), .branchOnNe(branchOnNeE),
		.aluOp(aluOpE), .aluResult(aluResultE), .storeData(storeDataE),
		.pcTarget(pcTarget), .pcSrc(pcSrc)
	);

	hazardUnit hazard (
		.rs1D(instrD[19:15]), .rs2D(instrD[24:20]), .rs1E(rs1E), .rs2E(rs2E),
		.rdE(rdE), .rdM(rdM), .rdW(rdW), .loadE(resultSrcE == resMem),
		.regWriteM(regWriteM), .regWriteW(regWriteW), .pcSrc(pcSrc),
		.fwdA(fwdA), .fwdB(fwdB), .stallF(stallF), .stallD(stallD),
		.flushD(flushD), .flushE(flushE)
	);

	// EX/MEM
	always_ff @(posedge clk) begin
		if (rst) begin
			{regWriteM, memWriteM, rdM} <= '0;
			resultSrcM <= resAlu;
		end else begin
			{regWriteM, memWriteM, rdM} <= {regWriteE, memWriteE, rdE};
			resultSrcM <= resultSrcE;
		end
	end

	always_ff @(posedge clk) begin
		{aluResultM, writeDataM, pcPlus4M} <= {aluResultE, storeDataE, pcPlus4E};
	end

	assign dataAddr  = aluResultM;
	assign writeData = writeDataM;
	assign memWrite  = memWriteM;

	// MEM/WB
	always_ff @(posedge clk) begin
		if (rst) begin
			{regWriteW, rdW} <= '0;
			resultSrcW <= resAlu;
		end else begin
			{regWriteW, rdW} <= {regWriteM, rdM};
			resultSrcW <= resultSrcM;
		end
	end

	always_ff @(posedge clk) begin
		{aluResultW, readDataW, pcPlus4W} <= {aluResultM, readData, pcPlus4M};
	end

	// writeback result, also the late forward source
	always_comb begin
		case (resultSrcW)
			resMem:     resultW = readDataW;
			resPcPlus4: resultW = pcPlus4W;
			default:    resultW = aluResultW;
		endcase
	end

endmodule

`default_nettype wire

// ==== sim/pipe_checker.sv ====
`default_nettype none

module pipeChecker #(
	parameter logic [rvPkg::xlen-1:0] resetPc = '0
) (
	input logic                   clk,
	input logic                   rst,
	input logic [rvPkg::xlen-1:0] pc,
	input logic                   memWrite
);

	timeunit 1ns;
	timeprecision 100ps;

	int errCount = 0;

	// reset leaves fetch at resetPc with no store pending
	resetState: assert property (@(posedge clk) rst |=> (pc == resetPc && !memWrite))
		else begin
			errCount++;
			$error("pc or memWrite wrong after reset");
		end

	pcAligned: assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00)
		else begin
			errCount++;
			$error("pc not word aligned: %h", pc);
		end

	memWriteKnown: assert property (@(posedge clk) disable iff (rst) !$isunknown(memWrite))
		else begin
			errCount++;
			$error("memWrite is unknown");
		end

endmodule

bind rvPipeTop pipeChecker #(.resetPc(resetPc)) pipeCheck (
	.clk(clk), .rst(rst), .pc(pc), .memWrite(memWrite)
);

`default_nettype wire

// ==== sim/testProgram.svh ====
// program builder, each task encodes one instruction and steps the reference model
// skip counts the wrong-path slots left behind a taken branch or a jump
task automatic emit(input logic [31:0] word, output logic live);
	imem[nextIdx] = word;
	nextIdx++;
	live = (skip == 0);
	if (!live) begin
		skip--;
	end
endtask

task automatic rOp(input logic [2:0] f3, input logic alt, input logic [4:0] rd, rs1, rs2);
	logic live;
	emit(rEnc(f3, alt, rd, rs1, rs2), live);
	if (live && rd != 5'd0) begin
		xs[rd] = refAlu(f3, alt, xs[rs1], xs[rs2]);
	end
endtask

task automatic iOp(input logic [2:0] f3, input logic [11:0] imm, input logic [4:0] rd, rs1);
	logic live;
	logic alt;
	// only srai carries the alternate bit inside the immediate
	alt = (f3 == 3'd5) && imm[10];
	emit(iEnc(7'b0010011, f3, rd, rs1, imm), live);
	if (live && rd != 5'd0) begin
		xs[rd] = refAlu(f3, alt, xs[rs1], {{20{imm[11]}}, imm});
	end
endtask

task automatic lw(input logic [4:0] rd, rs1, input logic [11:0] imm);
	logic live;
	logic [31:0] addr;
	emit(iEnc(7'b0000011, 3'b010, rd, rs1, imm), live);
	addr = xs[rs1] + {{20{imm[11]}}, imm};
	if (live && rd != 5'd0) begin
		xs[rd] = dmem[addr[8:2]];
	end
endtask

// sw of one register to the next free result slot
task automatic store(input logic [4:0] rs2);
	logic live;
	emit(sEnc(rs2, 5'd0, slotAddr), live);
	if (live) begin
		expAddr.push_back({20'd0, slotAddr});
		expData.push_back(xs[rs2]);
	end
	slotAddr += 12'd4;
endtask

task automatic branch(input logic [2:0] f3, input logic [4:0] rs1, rs2, input int hop);
	logic live;
	logic taken;
	logic [12:0] off;
	off = 13'((hop + 1) * 4);
	emit(bEnc(f3, rs1, rs2, off), live);
	// beq on equal, bne on not equal
	taken = (xs[rs1] == xs[rs2]) ^ (f3 == 3'b001);
	if (live && taken) begin
		skip = hop;
	end
endtask

task automatic jal(input logic [4:0] rd, input int hop);
	logic live;
	logic [20:0] off;
	off = 21'((hop + 1) * 4);
	emit(jEnc(rd, off), live);
	if (live) begin
		// nextIdx already points past the jal
		if (rd != 5'd0) begin
			xs[rd] = bootPc + 32'(nextIdx * 4);
		end
		skip = hop;
	end
endtask

task automatic loadProgram();
	logic live;
	for (int i = 0; i < 256; i++) begin
		imem[i] = '0;
	end
	for (int r = 0; r < 32; r++) begin
		xs[r] = '0;
	end
	nextIdx = 0;
	skip = 0;
	slotAddr = 12'h040;
	expAddr.delete();
	expData.delete();
	// second load feeds the add right behind it
	lw(5'd1, 5'd0, 12'h000);
	lw(5'd2, 5'd0, 12'h004);
	rOp(3'd0, 1'b0, 5'd3, 5'd1, 5'd2);
	rOp(3'd0, 1'b1, 5'd4, 5'd3, 5'd1);
	rOp(3'd7, 1'b0, 5'd5, 5'd4, 5'd3);
	rOp(3'd6, 1'b0, 5'd6, 5'd5, 5'd2);
	rOp(3'd4, 1'b0, 5'd7, 5'd6, 5'd4);
	rOp(3'd1, 1'b0, 5'd8, 5'd7, 5'd2);
	rOp(3'd5, 1'b0, 5'd9, 5'd8, 5'd1);
	rOp(3'd5, 1'b1, 5'd10, 5'd1, 5'd2);
	rOp(3'd2, 1'b0, 5'd11, 5'd1, 5'd2);
	rOp(3'd3, 1'b0, 5'd12, 5'd1, 5'd2);
	iOp(3'd0, 12'hf9c, 5'd13, 5'd9);
	iOp(3'd7, 12'h0f0, 5'd14, 5'd13);
	iOp(3'd6, 12'h801, 5'd15, 5'd14);
	iOp(3'd4, 12'hfff, 5'd16, 5'd15);
	iOp(3'd2, 12'h123, 5'd17, 5'd1);
	iOp(3'd3, 12'hfff, 5'd18, 5'd2);
	iOp(3'd1, 12'h005, 5'd19, 5'd16);
	iOp(3'd5, 12'h00b, 5'd20, 5'd1);
	iOp(3'd5, 12'h40b, 5'd21, 5'd1);
	for (int r = 3; r <= 21; r++) begin
		store(5'(r));
	end
	lw(5'd22, 5'd0, 12'h008);
	iOp(3'd0, 12'h001, 5'd23, 5'd22);
	store(5'd23);
	// taken beq, bne, then a beq on two different words
	branch(3'b000, 5'd1, 5'd1, 2);
	store(5'd3);
	store(5'd4);
	branch(3'b001, 5'd1, 5'd2, 2);
	store(5'd5);
	store(5'd6);
	branch(3'b000, 5'd1, 5'd2, 1);
	store(5'd7);
	jal(5'd24, 2);
	store(5'd8);
	store(5'd9);
	store(5'd24);
	// x0 must stay zero
	iOp(3'd0, 12'h07b, 5'd0, 5'd1);
	store(5'd0);
	emit(sEnc(5'd0, 5'd0, sentinelAddr[11:0]), live);
endtask

// ==== sim/rvPipeTb.sv ====
`default_nettype none

module rvPipeTb;

	timeunit 1ns;
	timeprecision 100ps;

	localparam logic [31:0] bootPc       = 32'h0000_0000;
	localparam logic [31:0] sentinelAddr = 32'h0000_0100;

	logic        clk;
	logic        rst;
	logic [31:0] pc, instr, dataAddr, writeData, readData;
	logic        memWrite;
	logic [31:0] fetchOff;

	logic [31:0] imem [256];
	logic [31:0] dmem [128];
	// reference register state while the program is built
	logic [31:0] xs [32];
	logic [31:0] expAddr [$];
	logic [31:0] expData [$];
	int          expIdx = 0;
	int          nextIdx;
	int          skip;
	logic [11:0] slotAddr;
	logic [31:0] lfsr;
	bit          done = 1'b0;

	rvPipeTop #(.resetPc(bootPc)) uut (
		.clk(clk), .rst(rst), .pc(pc), .instr(instr), .dataAddr(dataAddr),
		.writeData(writeData), .memWrite(memWrite), .readData(readData)
	);

	// both memories answer in the same cycle
	assign fetchOff = pc - bootPc;
	assign instr    = imem[fetchOff[9:2]];
	assign readData = dmem[dataAddr[8:2]];

	// taps 32, 22, 2, 1
	function automatic logic [31:0] lfsrStep(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// RV32I result for funct3 and the funct7 bit 5
	function automatic logic [31:0] refAlu(input logic [2:0] f3, input logic alt,
	                                        input logic [31:0] a, b);
		case (f3)
			3'd0: return alt ? a - b : a + b;
			3'd1: return a << b[4:0];
			3'd2: return {31'd0, $signed(a) < $signed(b)};
			3'd3: return {31'd0, a < b};
			3'd4: return a ^ b;
			3'd5: begin
				if (alt) begin
					return $signed(a) >>> b[4:0];
				end
				return a >> b[4:0];
			end
			3'd6: return a | b;
			default: return a & b;
		endcase
	endfunction

	function automatic logic [31:0] rEnc(input logic [2:0] f3, input logic alt,
	                                      input logic [4:0] rd, rs1, rs2);
		return {1'b0, alt, 5'd0, rs2, rs1, f3, rd, 7'b0110011};
	endfunction

	function automatic logic [31:0] iEnc(input logic [6:0] op, input logic [2:0] f3,
	                                      input logic [4:0] rd, rs1, input logic [11:0] imm);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic logic [31:0] sEnc(input logic [4:0] rs2, rs1, input logic [11:0] imm);
		return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
	endfunction

	function automatic logic [31:0] bEnc(input logic [2:0] f3, input logic [4:0] rs1, rs2,
	                                      input logic [12:0] off);
		return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
	endfunction

	function automatic logic [31:0] jEnc(input logic [4:0] rd, input logic [20:0] off);
		return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
	endfunction

	`include "testProgram.svh"

	task automatic stopWithError(input string why);
		$display("%s", why);
		$display("ERRORS FOUND");
		$fatal(1);
	endtask

	task automatic reportMismatch(input string name, input logic [31:0] got, exp);
		stopWithError($sformatf("CHECK FAILED time %0t %s got %h expected %h",
			$time, name, got, exp));
	endtask

	// words 0 to 7 from the LFSR, one step per bit
	task automatic fillData();
		logic [31:0] w;
		lfsr = 32'hbbb715b2;
		for (int a = 0; a < 128; a++) begin
			dmem[a] = '0;
		end
		for (int k = 0; k < 8; k++) begin
			w = '0;
			for (int b = 0; b < 32; b++) begin
				lfsr = lfsrStep(lfsr);
				w = {w[30:0], lfsr[0]};
			end
			dmem[k] = w;
		end
	endtask

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	always @(posedge clk) begin
		if (!rst && memWrite) begin
			dmem[dataAddr[8:2]] <= writeData;
		end
	end

	// store outputs are stable at the falling edge
	always @(negedge clk) begin
		if (!rst && !done && memWrite) begin
			if (dataAddr == sentinelAddr) begin
				allSeen: assert (expIdx == expAddr.size())
					else stopWithError($sformatf("sentinel store came after %0d of %0d stores",
						expIdx, expAddr.size()));
				done = 1'b1;
			end else begin
				notExtra: assert (expIdx < expAddr.size())
					else stopWithError($sformatf("unexpected store to %h", dataAddr));
				addrOk: assert (dataAddr === expAddr[expIdx])
					else reportMismatch("dataAddr", dataAddr, expAddr[expIdx]);
				dataOk: assert (writeData === expData[expIdx])
					else reportMismatch("writeData", writeData, expData[expIdx]);
				expIdx++;
			end
		end
	end

	initial begin
		int cycleLimit;
		int cycles;
		rst = 1'b1;
		fillData();
		loadProgram();
		// about ten cycles per instruction of the program
		cycleLimit = 10 * nextIdx;
		cycles = 0;
		repeat (4) @(posedge clk);
		rst <= 1'b0;
		while (!done && cycles < cycleLimit && uut.pipeCheck.errCount == 0) begin
			@(posedge clk);
			cycles++;
		end
		if (uut.pipeCheck.errCount != 0) begin
			stopWithError("an assertion on the core ports failed");
		end else if (done) begin
			$display("NO ERRORS");
			$finish;
		end else begin
			stopWithError($sformatf("timeout, no sentinel store within %0d cycles", cycleLimit));
		end
	end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+sim
src/rvPkg.sv
src/fetchStage.sv
src/decodeUnit.sv
src/regFile.sv
src/executeStage.sv
src/hazardUnit.sv
src/rvPipeTop.sv
sim/pipe_checker.sv
sim/rvPipeTb.sv

// ==== Bender.yml ====
package:
  name: rv_pipe

sources:
  - src/rvPkg.sv
  - src/fetchStage.sv
  - src/decodeUnit.sv
  - src/regFile.sv
  - src/executeStage.sv
  - src/hazardUnit.sv
  - src/rvPipeTop.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/pipe_checker.sv
      - sim/rvPipeTb.sv
